/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_hci_subsys
RTL_TOP    := hci_subsys_top
FLIST      := flist.f
SIM_FLAGS  := --binary --timing --timescale 1ns/1ps
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

# a $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
hw/hci_bus_pkg.sv
hw/hci_arb_pkg.sv
hw/hci_mux_ooo.sv
hw/hci_ctrl.sv
hw/hci_resp_queue.sv
hw/hci_sram_bank.sv
hw/hci_subsys_top.sv
test/tb_clk_gen.sv
test/tb_hci_subsys.sv

/* hw/hci_arb_pkg.sv */
/*
  controller states and arbitration modes of the multiplexer
*/
`default_nettype none

package hci_arb_pkg;

  // admission controller states
  typedef enum logic [1:0] {
    // grants allowed while the queue has room
    st_run     = 2'd0,
    // no grants, wait for outstanding responses
    st_drain   = 2'd1,
    // one cycle to reset the round-robin counter
    st_restart = 2'd2
  } ctrl_state_e;

  // how channel priorities are formed
  typedef enum logic {
    arb_rr     = 1'b0,
    arb_forced = 1'b1
  } arb_mode_e;

endpackage

`default_nettype wire

/* hw/hci_bus_pkg.sv */
/*
  bus widths and response opcodes shared by every block of the subsystem
  data_w must be a multiple of 8, addresses count whole words
*/
`default_nettype none

package hci_bus_pkg;

  // word address, wide enough for any bank size used here
  localparam int unsigned addr_w = 32;

  // one data word
  localparam int unsigned data_w = 32;

  // one enable per byte lane
  localparam int unsigned be_w = data_w / 8;

  // response opcode returned with every request, read or write
  typedef enum logic {
    // access done on an existing word
    resp_ok  = 1'b0,
    // address at or beyond the end of the bank
    resp_err = 1'b1
  } resp_opc_e;

endpackage

`default_nettype wire

/* hw/hci_ctrl.sv */
/*
  admission and flush control for the shared bank
  outstanding responses never exceed QUEUE_DEPTH, so the queue cannot overflow
  clear is ignored while a flush is already running
*/
`default_nettype none

module hci_ctrl #(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear,
  input  logic mem_req,
  input  logic q_valid,
  input  logic q_ready,
  output logic mem_gnt,
  output logic rr_clear,
  output logic busy
);

  localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

  hci_arb_pkg::ctrl_state_e state_q;
  hci_arb_pkg::ctrl_state_e state_d;
  logic [CNT_W-1:0]         out_cnt_q;
  logic                     grant;
  logic                     pop;

  // request accepted by the bank and response taken by a channel
  assign grant = mem_req && mem_gnt;
  assign pop   = q_valid && q_ready;

  // admission only while running and with room for one more response
  assign mem_gnt = (state_q == hci_arb_pkg::st_run) && (out_cnt_q < CNT_W'(QUEUE_DEPTH));

  assign rr_clear = (state_q == hci_arb_pkg::st_restart);
  assign busy     = (state_q != hci_arb_pkg::st_run);

  // responses in flight, in the bank stage or waiting in the queue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_cnt_q <= '0;
    end else if (grant && !pop) begin
      out_cnt_q <= out_cnt_q + 1'b1;
    end else if (pop && !grant) begin
      out_cnt_q <= out_cnt_q - 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      hci_arb_pkg::st_run: begin
        if (clear) begin
          state_d = hci_arb_pkg::st_drain;
        end
      end
      // wait until every granted request has been answered
      hci_arb_pkg::st_drain: begin
        if (out_cnt_q == '0) begin
          state_d = hci_arb_pkg::st_restart;
        end
      end
      // rr_clear is high for exactly this cycle
      hci_arb_pkg::st_restart: begin
        state_d = hci_arb_pkg::st_run;
      end
      default: begin
        state_d = hci_arb_pkg::st_run;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= hci_arb_pkg::st_run;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

/* hw/hci_mux_ooo.sv */
/*
  N-to-1 request arbiter tagging each grant with the source channel as ID
  NB_CHAN must be at least 2, equal forced priorities go to the lower index
  responses are routed back by ID, so the bank side must echo mem_id unchanged
*/
`default_nettype none

module hci_mux_ooo #(
  parameter  int unsigned NB_CHAN = 4,
  localparam int unsigned ID_W    = $clog2(NB_CHAN)
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          rr_clear,
  input  logic                                          priority_force,
  input  logic [NB_CHAN-1:0][ID_W-1:0]                  priority_vec,
  // channel requests
  input  logic [NB_CHAN-1:0]                            ch_req,
  input  logic [NB_CHAN-1:0][hci_bus_pkg::addr_w-1:0]   ch_add,
  input  logic [NB_CHAN-1:0]                            ch_wen,
  input  logic [NB_CHAN-1:0][hci_bus_pkg::data_w-1:0]   ch_data,
  input  logic [NB_CHAN-1:0][hci_bus_pkg::be_w-1:0]     ch_be,
  input  logic [NB_CHAN-1:0]                            ch_r_ready,
  // channel responses
  output logic [NB_CHAN-1:0]                            ch_gnt,
  output logic [NB_CHAN-1:0]                            ch_r_valid,
  output logic [NB_CHAN-1:0][hci_bus_pkg::data_w-1:0]   ch_r_data,
  output hci_bus_pkg::resp_opc_e [NB_CHAN-1:0]          ch_r_opc,
  // bank side
  output logic                                          mem_req,
  output logic [hci_bus_pkg::addr_w-1:0]                mem_add,
  output logic                                          mem_wen,
  output logic [hci_bus_pkg::data_w-1:0]                mem_data,
  output logic [hci_bus_pkg::be_w-1:0]                  mem_be,
  output logic [ID_W-1:0]                               mem_id,
  input  logic                                          mem_gnt,
  // response queue head
  input  logic                                          q_valid,
  input  logic [hci_bus_pkg::data_w-1:0]                q_data,
  input  hci_bus_pkg::resp_opc_e                        q_opc,
  input  logic [ID_W-1:0]                               q_id,
  output logic                                          q_ready
);

  hci_arb_pkg::arb_mode_e       arb_mode;
  logic [ID_W-1:0]              rr_cnt_q;
  logic [NB_CHAN-1:0][ID_W-1:0] chan_prio;
  logic [ID_W-1:0]              winner;

  assign arb_mode = priority_force ? hci_arb_pkg::arb_forced : hci_arb_pkg::arb_rr;

  // rotating base, one step per accepted request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_cnt_q <= '0;
    end else if (rr_clear) begin
      rr_cnt_q <= '0;
    end else if (mem_req && mem_gnt) begin
      if (rr_cnt_q == ID_W'(NB_CHAN - 1)) begin
        rr_cnt_q <= '0;
      end else begin
        rr_cnt_q <= rr_cnt_q + 1'b1;
      end
    end
  end

  for (genvar i = 0; i < NB_CHAN; i++) begin : g_chan
    // arb_rr gives (counter + i) mod NB_CHAN, arb_forced takes the external value
    assign chan_prio[i] = (arb_mode == hci_arb_pkg::arb_forced) ? priority_vec[i]
                        : ID_W'((int'(rr_cnt_q) + i) % NB_CHAN);

    assign ch_gnt[i] = (winner == ID_W'(i)) && ch_req[i] && mem_gnt;

    // response goes only to the channel named by the queue head
    assign ch_r_valid[i] = q_valid && (q_id == ID_W'(i));
    assign ch_r_data[i]  = q_data;
    assign ch_r_opc[i]   = q_opc;
  end

  // highest priority among the requesters wins
  always_comb begin : wta_comb
    logic            found;
    logic [ID_W-1:0] best;
    found  = 1'b0;
    best   = '0;
    winner = '0;
    for (int i = 0; i < NB_CHAN; i++) begin
      if (ch_req[i] && (!found || chan_prio[i] > best)) begin
        found  = 1'b1;
        best   = chan_prio[i];
        winner = ID_W'(i);
      end
    end
  end

  // forward the winner, its index travels as the ID
  assign mem_req  = |ch_req;
  assign mem_add  = ch_add[winner];
  assign mem_wen  = ch_wen[winner];
  assign mem_data = ch_data[winner];
  assign mem_be   = ch_be[winner];
  assign mem_id   = winner;

  // the head only leaves when its own channel takes it
  assign q_ready = ch_r_ready[q_id];

endmodule

`default_nettype wire

/* hw/hci_resp_queue.sv */
/*
  response FIFO between bank and multiplexer, one push per bank answer
  QUEUE_DEPTH must be at least 2, pushes on a full queue are not checked here
  admission in the controller keeps the level within QUEUE_DEPTH
*/
`default_nettype none

module hci_resp_queue #(
  parameter  int unsigned QUEUE_DEPTH = 4,
  parameter  int unsigned NB_CHAN     = 4,
  localparam int unsigned ID_W        = $clog2(NB_CHAN)
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           bank_valid,
  input  logic [hci_bus_pkg::data_w-1:0] bank_data,
  input  hci_bus_pkg::resp_opc_e         bank_opc,
  input  logic [ID_W-1:0]                bank_id,
  input  logic                           q_ready,
  output logic                           q_valid,
  output logic [hci_bus_pkg::data_w-1:0] q_data,
  output hci_bus_pkg::resp_opc_e         q_opc,
  output logic [ID_W-1:0]                q_id
);

  localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);
  localparam int unsigned LVL_W = $clog2(QUEUE_DEPTH + 1);

  logic [hci_bus_pkg::data_w-1:0] data_mem [QUEUE_DEPTH];
  hci_bus_pkg::resp_opc_e         opc_mem  [QUEUE_DEPTH];
  logic [ID_W-1:0]                id_mem   [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [LVL_W-1:0] level_q;
  logic             push;
  logic             pop;

  // wraps at QUEUE_DEPTH, also for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push = bank_valid;
  assign pop  = q_valid && q_ready;

  // head is visible the cycle after its push
  assign q_valid = (level_q != '0);
  assign q_data  = data_mem[rd_ptr_q];
  assign q_opc   = opc_mem[rd_ptr_q];
  assign q_id    = id_mem[rd_ptr_q];

  // storage, no reset
  always_ff @(posedge clk_i) begin
    if (push) begin
      data_mem[wr_ptr_q] <= bank_data;
      opc_mem[wr_ptr_q]  <= bank_opc;
      id_mem[wr_ptr_q]   <= bank_id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // level moves only when exactly one side is active
      if (push && !pop) begin
        level_q <= level_q + 1'b1;
      end else if (pop && !push) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/hci_sram_bank.sv */
/*
  single-port word memory answering every grant one cycle later
  the ID comes back unchanged; writes answer with zero data
  addresses at or above BANK_WORDS answer resp_err and leave memory untouched
*/
`default_nettype none

module hci_sram_bank #(
  parameter  int unsigned BANK_WORDS = 64,
  parameter  int unsigned NB_CHAN    = 4,
  localparam int unsigned ID_W       = $clog2(NB_CHAN)
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           mem_req,
  input  logic                           mem_gnt,
  input  logic [hci_bus_pkg::addr_w-1:0] mem_add,
  input  logic                           mem_wen,
  input  logic [hci_bus_pkg::data_w-1:0] mem_data,
  input  logic [hci_bus_pkg::be_w-1:0]   mem_be,
  input  logic [ID_W-1:0]                mem_id,
  output logic                           bank_valid,
  output logic [hci_bus_pkg::data_w-1:0] bank_data,
  output hci_bus_pkg::resp_opc_e         bank_opc,
  output logic [ID_W-1:0]                bank_id
);

  localparam int unsigned IDX_W = $clog2(BANK_WORDS);

  logic [hci_bus_pkg::data_w-1:0] mem_q [BANK_WORDS];
  logic                           access;
  logic                           in_range;
  logic [IDX_W-1:0]               idx;

  assign access   = mem_req && mem_gnt;
  assign in_range = (mem_add < hci_bus_pkg::addr_w'(BANK_WORDS));
  assign idx      = mem_add[IDX_W-1:0];

  // array and response payload, acted on at the grant edge
  always_ff @(posedge clk_i) begin
    if (access) begin
      // wen low is a write, only enabled byte lanes change
      if (in_range && !mem_wen) begin
        for (int b = 0; b < hci_bus_pkg::be_w; b++) begin
          if (mem_be[b]) begin
            mem_q[idx][8*b +: 8] <= mem_data[8*b +: 8];
          end
        end
      end
      bank_data <= (in_range && mem_wen) ? mem_q[idx] : '0;
      bank_opc  <= in_range ? hci_bus_pkg::resp_ok : hci_bus_pkg::resp_err;
      bank_id   <= mem_id;
    end
  end

  // push strobe toward the response queue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_valid <= 1'b0;
    end else begin
      bank_valid <= access;
    end
  end

endmodule

`default_nettype wire

/* hw/hci_subsys_top.sv */
/*
  NB_CHAN initiators sharing one memory bank through an out-of-order multiplexer
  NB_CHAN and QUEUE_DEPTH must be at least 2; responses of one channel stay in order
  a stalled queue head blocks the responses of every channel behind it
*/
`default_nettype none

module hci_subsys_top #(
  parameter  int unsigned NB_CHAN     = 4,
  parameter  int unsigned QUEUE_DEPTH = 4,
  parameter  int unsigned BANK_WORDS  = 64,
  localparam int unsigned ID_W        = $clog2(NB_CHAN)
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          clear,
  input  logic                                          priority_force,
  input  logic [NB_CHAN-1:0][ID_W-1:0]                  priority_vec,
  input  logic [NB_CHAN-1:0]                            ch_req,
  input  logic [NB_CHAN-1:0][hci_bus_pkg::addr_w-1:0]   ch_add,
  input  logic [NB_CHAN-1:0]                            ch_wen,
  input  logic [NB_CHAN-1:0][hci_bus_pkg::data_w-1:0]   ch_data,
  input  logic [NB_CHAN-1:0][hci_bus_pkg::be_w-1:0]     ch_be,
  input  logic [NB_CHAN-1:0]                            ch_r_ready,
  output logic [NB_CHAN-1:0]                            ch_gnt,
  output logic [NB_CHAN-1:0]                            ch_r_valid,
  output logic [NB_CHAN-1:0][hci_bus_pkg::data_w-1:0]   ch_r_data,
  output hci_bus_pkg::resp_opc_e [NB_CHAN-1:0]          ch_r_opc,
  output logic                                          busy
);

  // request path into the bank
  logic                           mem_req;
  logic                           mem_gnt;
  logic [hci_bus_pkg::addr_w-1:0] mem_add;
  logic                           mem_wen;
  logic [hci_bus_pkg::data_w-1:0] mem_data;
  logic [hci_bus_pkg::be_w-1:0]   mem_be;
  logic [ID_W-1:0]                mem_id;
  logic                           rr_clear;

  // bank answers, one cycle after grant
  logic                           bank_valid;
  logic [hci_bus_pkg::data_w-1:0] bank_data;
  hci_bus_pkg::resp_opc_e         bank_opc;
  logic [ID_W-1:0]                bank_id;

  // queue head toward the channels
  logic                           q_valid;
  logic                           q_ready;
  logic [hci_bus_pkg::data_w-1:0] q_data;
  hci_bus_pkg::resp_opc_e         q_opc;
  logic [ID_W-1:0]                q_id;

  hci_ctrl #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_ctrl (
    .clk_i, .rst_ni, .clear, .mem_req, .q_valid, .q_ready,
    .mem_gnt, .rr_clear, .busy
  );

  hci_mux_ooo #(
    .NB_CHAN (NB_CHAN)
  ) i_mux (
    .clk_i, .rst_ni, .rr_clear, .priority_force, .priority_vec,
    .ch_req, .ch_add, .ch_wen, .ch_data, .ch_be, .ch_r_ready,
    .ch_gnt, .ch_r_valid, .ch_r_data, .ch_r_opc,
    .mem_req, .mem_add, .mem_wen, .mem_data, .mem_be, .mem_id, .mem_gnt,
    .q_valid, .q_data, .q_opc, .q_id, .q_ready
  );

  hci_resp_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .NB_CHAN     (NB_CHAN)
  ) i_resp_queue (
    .clk_i, .rst_ni, .bank_valid, .bank_data, .bank_opc, .bank_id, .q_ready,
    .q_valid, .q_data, .q_opc, .q_id
  );

  hci_sram_bank #(
    .BANK_WORDS (BANK_WORDS),
    .NB_CHAN    (NB_CHAN)
  ) i_bank (
    .clk_i, .rst_ni, .mem_req, .mem_gnt, .mem_add, .mem_wen, .mem_data, .mem_be, .mem_id,
    .bank_valid, .bank_data, .bank_opc, .bank_id
  );

endmodule

`default_nettype wire

/* test/hci_patterns.mem */
// kind_chan_addr_wdata_be_force_prio_hold_chk_expect, kind 0 write 1 read 2 burst 3 clear 4 random
// hold is r_ready low cycles for kinds 0 and 1, grant count for 2, operation count for 4
0_0_0000_11111111_f_0_00_00_0_00000000
0_1_0001_22222222_f_0_00_00_0_00000000
0_2_0002_33333333_f_0_00_00_0_00000000
0_3_0003_44444444_f_0_00_00_0_00000000
1_0_0003_00000000_0_0_00_00_1_44444444
1_3_0000_00000000_0_0_00_00_1_11111111
// partial write, lanes 0 and 2
0_1_0002_aabbccdd_5_0_00_00_0_00000000
1_2_0002_00000000_0_0_00_00_1_33bb33dd
// beyond the bank, then the aliased low word is unchanged
0_2_0041_deadbeef_f_0_00_00_0_00000000
1_0_0041_00000000_0_0_00_00_1_00000000
1_1_0001_00000000_0_0_00_00_1_22222222
// round-robin burst, then forced priority with channel 1 on top
2_0_0000_00000000_0_0_00_0c_0_00000000
2_0_0000_00000000_0_1_8d_08_0_00000000
// channel 1 stalls the queue head until admission stops
0_1_0004_55555555_f_0_00_14_0_00000000
0_0_0005_66666666_f_0_00_00_0_00000000
0_2_0006_77777777_f_0_00_00_0_00000000
0_3_0007_88888888_f_0_00_00_0_00000000
0_0_0008_99999999_f_0_00_00_0_00000000
// flush with a held response in flight
0_3_0009_aaaaaaaa_f_0_00_0a_0_00000000
3_0_0000_00000000_0_0_00_00_0_00000000
2_0_0000_00000000_0_0_00_04_0_00000000
1_2_0009_00000000_0_0_00_00_1_aaaaaaaa
4_0_0000_00000000_0_0_00_20_0_00000000

/* test/tb_clk_gen.sv */
/*
  free-running testbench clock and active-low reset
  reset is released on a falling edge, clear of the DUT's sampling edge
*/
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 20,
  parameter int unsigned RST_CYCLES = 16
) (
  output logic clk_i,
  output logic rst_ni
);
  timeunit 1ns;
  timeprecision 1ps;

  // 50 % duty cycle
  initial begin
    clk_i = 1'b0;
    forever #(PERIOD_NS / 2) clk_i = ~clk_i;
  end

  // hold reset for RST_CYCLES rising edges
  initial begin
    rst_ni = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
  end

endmodule

`default_nettype wire

/* test/tb_hci_subsys.sv */
/*
  pattern-driven testbench for hci_subsys_top with default parameters
  inputs change on the falling edge, outputs are sampled 2 ns later
  expected data comes from a reference memory, order from one shared response list
*/
`default_nettype none

module tb_hci_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NB_CHAN    = 4;
  localparam int unsigned ID_W       = 2;
  localparam int unsigned BANK_WORDS = 64;
  localparam int unsigned RST_CYCLES = 16;
  localparam int unsigned MAX_PAT    = 64;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         clear;
  logic                         priority_force;
  logic [NB_CHAN-1:0][ID_W-1:0] priority_vec;
  logic [NB_CHAN-1:0]           ch_req;
  logic [NB_CHAN-1:0][31:0]     ch_add;
  logic [NB_CHAN-1:0]           ch_wen;
  logic [NB_CHAN-1:0][31:0]     ch_data;
  logic [NB_CHAN-1:0][3:0]      ch_be;
  logic [NB_CHAN-1:0]           ch_r_ready;
  logic [NB_CHAN-1:0]           ch_gnt;
  logic [NB_CHAN-1:0]           ch_r_valid;
  logic [NB_CHAN-1:0][31:0]     ch_r_data;
  hci_bus_pkg::resp_opc_e [NB_CHAN-1:0] ch_r_opc;
  logic                         busy;

  // values for the next falling edge
  logic [NB_CHAN-1:0]           req_nxt;
  logic [NB_CHAN-1:0]           wen_nxt;
  logic [NB_CHAN-1:0][31:0]     add_nxt;
  logic [NB_CHAN-1:0][31:0]     data_nxt;
  logic [NB_CHAN-1:0][3:0]      be_nxt;
  logic [NB_CHAN-1:0]           chk_nxt;
  logic [NB_CHAN-1:0][31:0]     chk_val;
  logic                         clear_nxt;
  logic                         frc_nxt;
  logic [NB_CHAN-1:0][ID_W-1:0] prio_nxt;

  // reference model and bookkeeping
  logic [31:0]              ref_mem [BANK_WORDS];
  bit   [BANK_WORDS-1:0]    known;
  // {chan, file check flag, file value, opcode, data}
  logic [67:0]              exp_q [$];
  logic [NB_CHAN-1:0]       held_prev;
  logic [NB_CHAN-1:0][31:0] data_prev;
  logic [115:0]             pat_mem [MAX_PAT];
  int                       hold_cnt [NB_CHAN];
  int                       rr_model;
  int                       stall_cnt;
  int                       burst_left;
  int                       npat;
  bit                       rand_ready;
  bit                       after_clear;
  int                       seed = 32'h6bd1;

  tb_clk_gen #(
    .PERIOD_NS  (20),
    .RST_CYCLES (RST_CYCLES)
  ) i_clk_gen (
    .clk_i,
    .rst_ni
  );

  hci_subsys_top DUT (
    .clk_i, .rst_ni, .clear, .priority_force, .priority_vec,
    .ch_req, .ch_add, .ch_wen, .ch_data, .ch_be, .ch_r_ready,
    .ch_gnt, .ch_r_valid, .ch_r_data, .ch_r_opc, .busy
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, act, exp));
    end
  endtask

  // highest priority value among requesters, ties to the lower index
  function automatic int pick_winner(input logic [3:0] req, input int base, input logic frc,
                                     input logic [7:0] pv);
    int best;
    int win;
    int p;
    best = -1;
    win  = -1;
    for (int i = 0; i < NB_CHAN; i++) begin
      p = frc ? int'(pv[2*i +: 2]) : (base + i) % NB_CHAN;
      if (req[i] && p > best) begin
        best = p;
        win  = i;
      end
    end
    return win;
  endfunction

  // model update for the request accepted at the coming rising edge
  task automatic take_grant(input int w);
    int          a;
    logic [31:0] d;
    logic        opc;
    // the round-robin counter restarts from zero after a flush
    if (after_clear) begin
      rr_model = 0;
      if (exp_q.size() != 0) begin
        abort_run("a grant came after clear before all outstanding responses returned");
      end
      check("first grant after clear", 32'(w), 32'(NB_CHAN - 1));
      after_clear = 1'b0;
    end
    check("granted channel", 32'(w),
          32'(pick_winner(ch_req, rr_model, priority_force, priority_vec)));
    rr_model = (rr_model + 1) % NB_CHAN;
    d   = '0;
    opc = 1'b0;
    a   = int'(ch_add[w]);
    if (ch_add[w] >= BANK_WORDS) begin
      opc = 1'b1;
    end else if (!ch_wen[w]) begin
      for (int b = 0; b < 4; b++) begin
        if (ch_be[w][b]) ref_mem[a][8*b +: 8] = ch_data[w][8*b +: 8];
      end
      if (ch_be[w] == 4'hf) known[a] = 1'b1;
    end else begin
      d = ref_mem[a];
    end
    exp_q.push_back({2'(w), chk_nxt[w], chk_val[w], opc, d});
    chk_nxt[w] = 1'b0;
    // a burst keeps every channel requesting until its grant count is used up
    if (burst_left > 0) begin
      burst_left--;
      if (burst_left == 0) req_nxt = '0;
    end else begin
      req_nxt[w] = 1'b0;
    end
  endtask

  task automatic check_response(input int c);
    int          idx;
    logic [67:0] e;
    // a response not taken must stay put
    if (held_prev[c]) begin
      check($sformatf("ch_r_valid[%0d]", c), 32'(ch_r_valid[c]), 32'd1);
      check($sformatf("ch_r_data[%0d]", c), ch_r_data[c], data_prev[c]);
    end
    held_prev[c] = ch_r_valid[c] && !ch_r_ready[c];
    data_prev[c] = ch_r_data[c];
    if (ch_r_valid[c] && ch_r_ready[c]) begin
      idx = -1;
      for (int i = 0; i < exp_q.size(); i++) begin
        if (idx < 0 && exp_q[i][67:66] == 2'(c)) idx = i;
      end
      if (idx < 0) begin
        abort_run($sformatf("response on channel %0d with no request outstanding", c));
      end else begin
        e = exp_q[idx];
        exp_q.delete(idx);
        check($sformatf("ch_r_opc[%0d]", c), 32'(ch_r_opc[c]), 32'(e[32]));
        check($sformatf("ch_r_data[%0d]", c), ch_r_data[c], e[31:0]);
        if (e[65]) check($sformatf("ch_r_data[%0d] vs pattern", c), ch_r_data[c], e[64:33]);
      end
    end
  endtask

  task automatic observe();
    int w;
    if (busy) begin
      if (ch_gnt != '0) abort_run("a channel was granted while the controller was flushing");
    end else if (ch_req != '0 && ch_gnt == '0) begin
      stall_cnt++;
    end
    w = -1;
    for (int c = 0; c < NB_CHAN; c++) begin
      if (ch_gnt[c] && w >= 0) begin
        abort_run("more than one channel granted in the same cycle");
      end else if (ch_gnt[c]) begin
        w = c;
      end
    end
    if (w >= 0) take_grant(w);
    for (int c = 0; c < NB_CHAN; c++) check_response(c);
  endtask

  // drive at the falling edge of each clock and sample once inputs have settled
  task automatic tick();
    logic [NB_CHAN-1:0] rnd;
    rnd = NB_CHAN'($random(seed));
    @(negedge clk_i);
    ch_req         = req_nxt;
    ch_wen         = wen_nxt;
    ch_add         = add_nxt;
    ch_data        = data_nxt;
    ch_be          = be_nxt;
    clear          = clear_nxt;
    priority_force = frc_nxt;
    priority_vec   = prio_nxt;
    for (int c = 0; c < NB_CHAN; c++) begin
      ch_r_ready[c] = (hold_cnt[c] == 0) && (!rand_ready || rnd[c]);
      if (hold_cnt[c] > 0) hold_cnt[c]--;
    end
    #2;
    observe();
  endtask

  task automatic issue(input int c, input logic wen, input logic [31:0] a,
                       input logic [31:0] d, input logic [3:0] be, input logic chk,
                       input logic [31:0] ev);
    wen_nxt[c]  = wen;
    add_nxt[c]  = a;
    data_nxt[c] = d;
    be_nxt[c]   = be;
    chk_nxt[c]  = chk;
    chk_val[c]  = ev;
    req_nxt[c]  = 1'b1;
    while (req_nxt[c]) tick();
  endtask

  // every channel requests during the drain and waits for its end
  task automatic flush();
    clear_nxt = 1'b1;
    tick();
    clear_nxt = 1'b0;
    for (int i = 0; i < NB_CHAN; i++) begin
      wen_nxt[i] = 1'b1;
      add_nxt[i] = 32'(i);
      chk_nxt[i] = 1'b0;
    end
    after_clear = 1'b1;
    burst_left  = 1;
    req_nxt     = '1;
    tick();
    check("busy", 32'(busy), 32'd1);
    while (burst_left > 0) tick();
  endtask

  // random channel, address and direction with reads only of fully known words
  task automatic random_traffic(input int n);
    int          c;
    int          a;
    logic [31:0] r;
    logic [31:0] d;
    rand_ready = 1'b1;
    repeat (n) begin
      c = int'($unsigned($random(seed)) % NB_CHAN);
      a = int'($unsigned($random(seed)) % 16);
      r = $random(seed);
      d = $random(seed);
      issue(c, known[a] && r[0], 32'(a), d, 4'hf, 1'b0, '0);
    end
    rand_ready = 1'b0;
  endtask

  task automatic run_pattern(input logic [115:0] p);
    int c;
    c        = int'(p[109:108]);
    frc_nxt  = p[52];
    prio_nxt = p[51:44];
    case (p[115:112])
      4'h0, 4'h1: begin
        hold_cnt[c] = int'(p[43:36]);
        issue(c, p[112], 32'(p[107:92]), p[91:60], p[59:56], p[32], p[31:0]);
      end
      // all channels read addr + index while the hold field counts grants
      4'h2: begin
        for (int i = 0; i < NB_CHAN; i++) begin
          wen_nxt[i] = 1'b1;
          add_nxt[i] = 32'(p[107:92]) + 32'(i);
          chk_nxt[i] = 1'b0;
        end
        burst_left = int'(p[43:36]);
        req_nxt    = '1;
        while (burst_left > 0) tick();
      end
      4'h3: flush();
      4'h4: random_traffic(int'(p[43:36]));
      default: abort_run("unknown operation kind in the pattern file");
    endcase
  endtask

  initial begin : watchdog
    wait (npat > 0);
    repeat (RST_CYCLES + npat * 40) @(posedge clk_i);
    abort_run("simulation timed out, the DUT stopped granting or answering");
  end

  initial begin : main
    clear          = 1'b0;
    priority_force = 1'b0;
    priority_vec   = '0;
    ch_req         = '0;
    ch_wen         = '1;
    ch_add         = '0;
    ch_data        = '0;
    ch_be          = '0;
    ch_r_ready     = '1;
    req_nxt        = '0;
    wen_nxt        = '1;
    add_nxt        = '0;
    data_nxt       = '0;
    be_nxt         = '0;
    chk_nxt        = '0;
    chk_val        = '0;
    clear_nxt      = 1'b0;
    frc_nxt        = 1'b0;
    prio_nxt       = '0;
    held_prev      = '0;
    data_prev      = '0;
    known          = '0;
    for (int c = 0; c < NB_CHAN; c++) hold_cnt[c] = 0;
    // kind f marks the end of the list
    for (int i = 0; i < MAX_PAT; i++) pat_mem[i] = '1;
    $readmemh("test/hci_patterns.mem", pat_mem);
    while (npat < MAX_PAT && pat_mem[npat][115:112] != 4'hf) npat++;
    if (npat == 0) abort_run("pattern file is empty or missing");
    @(posedge rst_ni);
    for (int i = 0; i < npat; i++) run_pattern(pat_mem[i]);
    while (exp_q.size() != 0) tick();
    if (stall_cnt == 0) begin
      abort_run("grants never stopped under back-pressure");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
